// ==== Makefile ====
# Verilator build and run for the dataflow testbench
VERILATOR ?= verilator
TOP       ?= dataflowTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# the log decides pass or fail, not the exit code of the binary
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

check: run
	@echo "check finished, see $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
+incdir+include
rtl/dataflowPkg.sv
rtl/internalBus.sv
rtl/alu.sv
rtl/programCounterLogic.sv
rtl/processStatusRegister.sv
rtl/internalDataflow.sv
rtl/top.sv
tests/dataflowTb.sv

// ==== rtl/alu.sv ====
module alu
  import dataflowPkg::*;
(
  input  logic                 hwclk,
  input  logic                 rstN,
  input  logic [flagCount-1:0] flags,
  input  logic [7:0]           sbIn,
  input  logic [7:0]           dbIn,
  output logic [7:0]           result,
  output logic                 carryOut,
  output logic                 overflowOut
);

  // operand registers
  logic [7:0] aiReg;
  logic [7:0] biReg;

  // adder with carry out in bit 8
  logic [8:0] sum;
  logic       sumOverflow;

  always_comb begin
    sum = {1'b0, aiReg} + {1'b0, biReg} + {8'b0, flags[aluCarryIn]};
    // same operand signs but sign of sum flipped
    sumOverflow = ~(aiReg[7] ^ biReg[7]) & (aiReg[7] ^ sum[7]);
  end

  always_ff @(posedge hwclk) begin
    if (!rstN) begin
      aiReg       <= 8'h00;
      biReg       <= 8'h00;
      result      <= 8'h00;
      carryOut    <= 1'b0;
      overflowOut <= 1'b0;
    end else begin
      // AI taps the special bus and BI the data bus
      if (flags[loadAluA]) begin
        aiReg <= sbIn;
      end
      if (flags[loadAluB]) begin
        biReg <= dbIn;
      end
      // hold register only changes on an operation flag
      if (flags[aluAdd]) begin
        result      <= sum[7:0];
        carryOut    <= sum[8];
        overflowOut <= sumOverflow;
      end else if (flags[aluAnd]) begin
        result      <= aiReg & biReg;
        carryOut    <= 1'b0;
        overflowOut <= 1'b0;
      end else if (flags[aluOr]) begin
        result      <= aiReg | biReg;
        carryOut    <= 1'b0;
        overflowOut <= 1'b0;
      end else if (flags[aluXor]) begin
        result      <= aiReg ^ biReg;
        carryOut    <= 1'b0;
        overflowOut <= 1'b0;
      end else if (flags[aluShr]) begin
        // logical shift with bit 0 falling into carry
        result      <= {1'b0, aiReg[7:1]};
        carryOut    <= aiReg[0];
        overflowOut <= 1'b0;
      end
    end
  end

endmodule

// ==== rtl/dataflowPkg.sv ====
package dataflowPkg;

  // control flag vector width
  // indices 38 and 39 are spare
  localparam int flagCount = 40;

  // DB bus sources
  localparam int dbFromExt    = 0;
  localparam int dbFromAcc    = 1;
  localparam int dbFromStatus = 2;
  localparam int dbFromPcl    = 3;
  localparam int dbFromPch    = 4;
  localparam int dbFromSb     = 5;

  // SB bus sources
  localparam int sbFromX   = 6;
  localparam int sbFromY   = 7;
  localparam int sbFromAcc = 8;
  localparam int sbFromSp  = 9;
  localparam int sbFromAlu = 10;
  localparam int sbFromDb  = 11;

  // low address bus sources
  localparam int adlFromPcl = 12;
  localparam int adlFromSp  = 13;
  localparam int adlFromAlu = 14;

  // high address bus sources
  localparam int adhFromPch = 15;
  localparam int adhFromDb  = 16;
  localparam int adhFromSb  = 17;

  // register load enables
  localparam int loadX   = 18;
  localparam int loadY   = 19;
  localparam int loadAcc = 20;
  localparam int loadSp  = 21;
  localparam int loadAbl = 22;
  localparam int loadAbh = 23;
  localparam int loadDor = 24;

  // alu operand loads with AI from SB and BI from DB
  localparam int loadAluA   = 25;
  localparam int loadAluB   = 26;
  // operation selects
  localparam int aluAdd     = 27;
  localparam int aluAnd     = 28;
  localparam int aluOr      = 29;
  localparam int aluXor     = 30;
  localparam int aluShr     = 31;
  localparam int aluCarryIn = 32;

  // program counter
  localparam int pcIncrement       = 33;
  localparam int loadPcFromAddress = 34;

  // status register updates
  localparam int statusLoadNz  = 35;
  localparam int statusLoadCv  = 36;
  localparam int statusLoadAll = 37;

  // status bit positions with the rest reading zero
  localparam int statusC = 0;
  localparam int statusZ = 1;
  localparam int statusV = 6;
  localparam int statusN = 7;

endpackage

// ==== rtl/internalBus.sv ====
// precharged bus with wired-AND sources
module internalBus #(
  parameter int sourceCount = 2
) (
  input  logic [sourceCount-1:0][7:0] sources,
  input  logic [sourceCount-1:0]      enables,
  output logic [7:0]                  value
);

  // open-drain behaviour
  // idle bus floats high through the precharge
  // any driver can only pull bits low
  always_comb begin
    value = 8'hFF;
    for (int i = 0; i < sourceCount; i++) begin
      // disabled sources leave the bus alone
      if (enables[i]) begin
        value = value & sources[i];
      end
    end
  end

endmodule

// ==== rtl/internalDataflow.sv ====
module internalDataflow
  import dataflowPkg::*;
(
  input  logic                 hwclk,
  input  logic                 rstN,
  input  logic [flagCount-1:0] flags,
  input  logic [7:0]           externalDbRead,
  output logic [7:0]           addressLow,
  output logic [7:0]           addressHigh,
  output logic [7:0]           dbWrite,
  output logic [7:0]           status
);

  // general registers
  logic [7:0] xReg;
  logic [7:0] yReg;
  logic [7:0] accReg;
  logic [7:0] spReg;
  // external interface registers
  logic [7:0] ablReg;
  logic [7:0] abhReg;
  logic [7:0] dorReg;

  // resolved bus values
  logic [7:0] dbValue;
  logic [7:0] sbValue;
  logic [7:0] adlValue;
  logic [7:0] adhValue;

  // SB drivers other than the DB pass
  logic [4:0][7:0] sbRegSources;
  logic [4:0]      sbRegEnables;
  logic [7:0]      sbDirect;

  // submodule outputs
  logic [7:0] aluResult;
  logic       aluCarry;
  logic       aluOverflow;
  logic [7:0] pcl;
  logic [7:0] pch;

  assign sbRegSources = {aluResult, spReg, accReg, yReg, xReg};
  assign sbRegEnables = {flags[sbFromAlu], flags[sbFromSp], flags[sbFromAcc],
                         flags[sbFromY], flags[sbFromX]};

  // SB as seen by the SB to DB pass
  // both passes are never on together
  // so the DB pass term can be left out here
  always_comb begin
    sbDirect = 8'hFF;
    for (int i = 0; i < 5; i++) begin
      if (sbRegEnables[i]) begin
        sbDirect = sbDirect & sbRegSources[i];
      end
    end
  end

  // data bus
  internalBus #(.sourceCount(6)) dbBus_i (
    .sources({sbDirect, pch, pcl, status, accReg, externalDbRead}),
    .enables({flags[dbFromSb], flags[dbFromPch], flags[dbFromPcl],
              flags[dbFromStatus], flags[dbFromAcc], flags[dbFromExt]}),
    .value  (dbValue)
  );

  // special bus whose top source is the pass from DB
  internalBus #(.sourceCount(6)) sbBus_i (
    .sources({dbValue, sbRegSources}),
    .enables({flags[sbFromDb], sbRegEnables}),
    .value  (sbValue)
  );

  // address low
  internalBus #(.sourceCount(3)) adlBus_i (
    .sources({aluResult, spReg, pcl}),
    .enables({flags[adlFromAlu], flags[adlFromSp], flags[adlFromPcl]}),
    .value  (adlValue)
  );

  // address high
  internalBus #(.sourceCount(3)) adhBus_i (
    .sources({sbValue, dbValue, pch}),
    .enables({flags[adhFromSb], flags[adhFromDb], flags[adhFromPch]}),
    .value  (adhValue)
  );

  alu alu_i (
    .hwclk      (hwclk),
    .rstN       (rstN),
    .flags      (flags),
    .sbIn       (sbValue),
    .dbIn       (dbValue),
    .result     (aluResult),
    .carryOut   (aluCarry),
    .overflowOut(aluOverflow)
  );

  programCounterLogic pc_i (
    .hwclk(hwclk),
    .rstN (rstN),
    .flags(flags),
    .adlIn(adlValue),
    .adhIn(adhValue),
    .pcl  (pcl),
    .pch  (pch)
  );

  processStatusRegister psr_i (
    .hwclk      (hwclk),
    .rstN       (rstN),
    .flags      (flags),
    .dbIn       (dbValue),
    .aluCarry   (aluCarry),
    .aluOverflow(aluOverflow),
    .status     (status)
  );

  // X, Y, ACC and SP all load from SB
  // ABL and ABH take the address buses and DOR takes DB
  always_ff @(posedge hwclk) begin
    if (!rstN) begin
      xReg   <= 8'h00;
      yReg   <= 8'h00;
      accReg <= 8'h00;
      spReg  <= 8'h00;
      ablReg <= 8'h00;
      abhReg <= 8'h00;
      dorReg <= 8'h00;
    end else begin
      if (flags[loadX]) begin
        xReg <= sbValue;
      end
      if (flags[loadY]) begin
        yReg <= sbValue;
      end
      if (flags[loadAcc]) begin
        accReg <= sbValue;
      end
      if (flags[loadSp]) begin
        spReg <= sbValue;
      end
      if (flags[loadAbl]) begin
        ablReg <= adlValue;
      end
      if (flags[loadAbh]) begin
        abhReg <= adhValue;
      end
      if (flags[loadDor]) begin
        dorReg <= dbValue;
      end
    end
  end

  // pins follow the registers directly
  assign addressLow  = ablReg;
  assign addressHigh = abhReg;
  assign dbWrite     = dorReg;

endmodule

// ==== rtl/processStatusRegister.sv ====
module processStatusRegister
  import dataflowPkg::*;
(
  input  logic                 hwclk,
  input  logic                 rstN,
  input  logic [flagCount-1:0] flags,
  input  logic [7:0]           dbIn,
  input  logic                 aluCarry,
  input  logic                 aluOverflow,
  output logic [7:0]           status
);

  // only N, V, Z and C are ever written
  // unused bits stay at their reset value of zero
  logic [7:0] statusReg;

  always_ff @(posedge hwclk) begin
    if (!rstN) begin
      statusReg <= 8'h00;
    end else if (flags[statusLoadAll]) begin
      // full restore from the data bus
      statusReg[statusN] <= dbIn[statusN];
      statusReg[statusV] <= dbIn[statusV];
      statusReg[statusZ] <= dbIn[statusZ];
      statusReg[statusC] <= dbIn[statusC];
    end else begin
      // sign and zero of the byte on DB
      if (flags[statusLoadNz]) begin
        statusReg[statusN] <= dbIn[7];
        statusReg[statusZ] <= (dbIn == 8'h00);
      end
      // flags kept beside the alu hold register
      if (flags[statusLoadCv]) begin
        statusReg[statusC] <= aluCarry;
        statusReg[statusV] <= aluOverflow;
      end
    end
  end

  assign status = statusReg;

endmodule

// ==== rtl/programCounterLogic.sv ====
module programCounterLogic
  import dataflowPkg::*;
(
  input  logic                 hwclk,
  input  logic                 rstN,
  input  logic [flagCount-1:0] flags,
  input  logic [7:0]           adlIn,
  input  logic [7:0]           adhIn,
  output logic [7:0]           pcl,
  output logic [7:0]           pch
);

  // low byte incrementer
  logic [7:0] pclNext;
  logic       pclCarry;
  // high byte only moves when the low byte wraps
  logic [7:0] pchNext;

  always_comb begin
    {pclCarry, pclNext} = {1'b0, pcl} + 9'd1;
    pchNext = pch + {7'b0, pclCarry};
  end

  always_ff @(posedge hwclk) begin
    if (!rstN) begin
      pcl <= 8'h00;
      pch <= 8'h00;
    end else if (flags[loadPcFromAddress]) begin
      // jump target straight off the address buses
      pcl <= adlIn;
      pch <= adhIn;
    end else if (flags[pcIncrement]) begin
      pcl <= pclNext;
      pch <= pchNext;
    end
  end

endmodule

// ==== rtl/top.sv ====
module top
  import dataflowPkg::*;
(
  input  logic                 hwclk,
  input  logic                 rstN,
  input  logic [flagCount-1:0] flags,
  input  logic [7:0]           externalDbRead,
  output logic [7:0]           addressLow,
  output logic [7:0]           addressHigh,
  output logic [7:0]           dbWrite,
  output logic [7:0]           status
);

  // flags come straight from the pins each cycle
  // no decoder sits in front of the datapath
  internalDataflow dataflow_i (
    .hwclk         (hwclk),
    .rstN          (rstN),
    .flags         (flags),
    .externalDbRead(externalDbRead),
    .addressLow    (addressLow),
    .addressHigh   (addressHigh),
    .dbWrite       (dbWrite),
    .status        (status)
  );

endmodule

// ==== include/dataflowVectors.svh ====
`ifndef DATAFLOW_VECTORS_SVH
`define DATAFLOW_VECTORS_SVH

// one row per cycle
// expected columns are the outputs after the following edge
typedef struct packed {
  logic [flagCount-1:0] flags;
  logic [7:0]           dbRead;
  logic [7:0]           expLow;
  logic [7:0]           expHigh;
  logic [7:0]           expDbWrite;
  logic [7:0]           expStatus;
} vectorRow;

// single set bit for building flag masks
localparam logic [flagCount-1:0] one = 1;

localparam int vectorCount = 36;

// column order is flags, dbRead, addressLow, addressHigh, dbWrite and status
localparam vectorRow vectorTable [vectorCount] = '{
  '{'0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
  // 5A into ACC, then out through DOR and ABH
  '{one << dbFromExt | one << sbFromDb | one << loadAcc, 8'h5A, 8'h00, 8'h00, 8'h00, 8'h00},
  '{one << dbFromAcc | one << loadDor, 8'h00, 8'h00, 8'h00, 8'h5A, 8'h00},
  '{one << sbFromAcc | one << adhFromSb | one << loadAbh, 8'h00, 8'h00, 8'h5A, 8'h5A, 8'h00},
  // X to Y to SP to ABL
  '{one << dbFromExt | one << sbFromDb | one << loadX, 8'h3C, 8'h00, 8'h5A, 8'h5A, 8'h00},
  '{one << sbFromX | one << loadY, 8'h00, 8'h00, 8'h5A, 8'h5A, 8'h00},
  '{one << sbFromY | one << loadSp, 8'h00, 8'h00, 8'h5A, 8'h5A, 8'h00},
  '{one << adlFromSp | one << loadAbl, 8'h00, 8'h3C, 8'h5A, 8'h5A, 8'h00},
  // undriven bus and wired AND
  '{one << loadAbl, 8'h00, 8'hFF, 8'h5A, 8'h5A, 8'h00},
  '{one << dbFromExt | one << dbFromAcc | one << loadDor, 8'hF0, 8'hFF, 8'h5A, 8'h50, 8'h00},
  // 7F + 01
  '{one << dbFromExt | one << sbFromDb | one << loadAluA, 8'h7F, 8'hFF, 8'h5A, 8'h50, 8'h00},
  '{one << dbFromExt | one << loadAluB, 8'h01, 8'hFF, 8'h5A, 8'h50, 8'h00},
  '{one << aluAdd, 8'h00, 8'hFF, 8'h5A, 8'h50, 8'h00},
  '{one << sbFromAlu | one << dbFromSb | one << loadDor | one << statusLoadCv,
    8'h00, 8'hFF, 8'h5A, 8'h80, 8'h40},
  // F0 + 20
  '{one << dbFromExt | one << sbFromDb | one << loadAluA, 8'hF0, 8'hFF, 8'h5A, 8'h80, 8'h40},
  '{one << dbFromExt | one << loadAluB, 8'h20, 8'hFF, 8'h5A, 8'h80, 8'h40},
  '{one << aluAdd, 8'h00, 8'hFF, 8'h5A, 8'h80, 8'h40},
  '{one << adlFromAlu | one << loadAbl | one << statusLoadCv, 8'h00, 8'h10, 8'h5A, 8'h80, 8'h01},
  // logic ops on CC and AA
  '{one << dbFromExt | one << sbFromDb | one << loadAluA, 8'hCC, 8'h10, 8'h5A, 8'h80, 8'h01},
  '{one << dbFromExt | one << loadAluB, 8'hAA, 8'h10, 8'h5A, 8'h80, 8'h01},
  '{one << aluAnd, 8'h00, 8'h10, 8'h5A, 8'h80, 8'h01},
  '{one << sbFromAlu | one << dbFromSb | one << loadDor | one << aluOr,
    8'h00, 8'h10, 8'h5A, 8'h88, 8'h01},
  '{one << sbFromAlu | one << dbFromSb | one << loadDor | one << aluXor,
    8'h00, 8'h10, 8'h5A, 8'hEE, 8'h01},
  '{one << sbFromAlu | one << dbFromSb | one << loadDor, 8'h00, 8'h10, 8'h5A, 8'h66, 8'h01},
  // shift right of 81
  '{one << dbFromExt | one << sbFromDb | one << loadAluA, 8'h81, 8'h10, 8'h5A, 8'h66, 8'h01},
  '{one << aluShr, 8'h00, 8'h10, 8'h5A, 8'h66, 8'h01},
  '{one << sbFromAlu | one << dbFromSb | one << loadDor | one << statusLoadCv,
    8'h00, 8'h10, 8'h5A, 8'h40, 8'h01},
  // PC 00FF then one increment
  '{one << dbFromExt | one << adhFromDb | one << loadPcFromAddress,
    8'h00, 8'h10, 8'h5A, 8'h40, 8'h01},
  '{one << pcIncrement, 8'h00, 8'h10, 8'h5A, 8'h40, 8'h01},
  '{one << adlFromPcl | one << adhFromPch | one << loadAbl | one << loadAbh,
    8'h00, 8'h00, 8'h01, 8'h40, 8'h01},
  // status from DB
  '{one << dbFromExt | one << statusLoadNz, 8'h00, 8'h00, 8'h01, 8'h40, 8'h03},
  '{one << dbFromExt | one << statusLoadNz, 8'h80, 8'h00, 8'h01, 8'h40, 8'h81},
  '{one << dbFromExt | one << statusLoadAll, 8'hC3, 8'h00, 8'h01, 8'h40, 8'hC3},
  '{one << dbFromStatus | one << loadDor, 8'h00, 8'h00, 8'h01, 8'hC3, 8'hC3},
  // add with carry in on 81 and AA
  '{one << aluAdd | one << aluCarryIn, 8'h00, 8'h00, 8'h01, 8'hC3, 8'hC3},
  '{one << sbFromAlu | one << dbFromSb | one << loadDor | one << statusLoadCv,
    8'h00, 8'h00, 8'h01, 8'h2C, 8'hC3}
};

`endif

// ==== tests/dataflowTb.sv ====
module dataflowTb
  import dataflowPkg::*;
;

  `include "dataflowVectors.svh"

  // reset length in clock cycles
  localparam int resetCycles = 8;
  localparam int clockPeriod = 20;
  // twice the nominal run length
  localparam int watchdogTime = (vectorCount + resetCycles) * clockPeriod * 2;

  logic                 hwclk;
  logic                 rstN;
  logic [flagCount-1:0] flags;
  logic [7:0]           externalDbRead;
  logic [7:0]           addressLow;
  logic [7:0]           addressHigh;
  logic [7:0]           dbWrite;
  logic [7:0]           status;

  top dut_i (
    .hwclk         (hwclk),
    .rstN          (rstN),
    .flags         (flags),
    .externalDbRead(externalDbRead),
    .addressLow    (addressLow),
    .addressHigh   (addressHigh),
    .dbWrite       (dbWrite),
    .status        (status)
  );

  // free running clock
  always #(clockPeriod / 2) hwclk = ~hwclk;

  // compare one byte against its expected value
  task automatic compareByte(input logic [7:0] actual, input logic [7:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("MISMATCH at time %0t: %s expected %h got %h", $time, what, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopping on first mismatch");
    end
  endtask

  // all four outputs against one table row
  task automatic checkRow(input int index, input vectorRow row);
    compareByte(addressLow, row.expLow, $sformatf("row %0d addressLow", index));
    compareByte(addressHigh, row.expHigh, $sformatf("row %0d addressHigh", index));
    compareByte(dbWrite, row.expDbWrite, $sformatf("row %0d dbWrite", index));
    compareByte(status, row.expStatus, $sformatf("row %0d status", index));
  endtask

  initial begin
    vectorRow row;
    hwclk          = 1'b0;
    rstN           = 1'b0;
    flags          = '0;
    externalDbRead = 8'h00;

    // hold reset, then release just after an edge
    repeat (resetCycles) @(posedge hwclk);
    #2;
    rstN = 1'b1;

    // outputs must already be cleared by the reset
    compareByte(addressLow, 8'h00, "addressLow after reset");
    compareByte(addressHigh, 8'h00, "addressHigh after reset");
    compareByte(dbWrite, 8'h00, "dbWrite after reset");
    compareByte(status, 8'h00, "status after reset");

    for (int i = 0; i < vectorCount; i++) begin
      row = vectorTable[i];
      // drive at edge plus 2
      flags          = row.flags;
      externalDbRead = row.dbRead;
      @(posedge hwclk);
      // registers settled one unit after the edge
      #1;
      checkRow(i, row);
      #1;
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

  // hang guard
  initial begin
    #(watchdogTime);
    $display("ERROR: simulation hung, the table did not finish within %0d time units",
             watchdogTime);
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule
